//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_fetch
FILELIST  = sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /^Testbench passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- fetch_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_ctrl (
  input  wire                         clk,
  input  wire                         rst,
  output logic [fetch_pkg::xlen-1:0]  fetch_pc_o,
  output logic                        fetch_req_o,
  input  wire                         hit_i,
  input  wire [fetch_pkg::xlen-1:0]   hit_inst_i,
  output logic                        flush_o,
  output logic                        inst_valid_o,
  output logic [fetch_pkg::xlen-1:0]  inst_o,
  output logic [fetch_pkg::xlen-1:0]  pc_o,
  input  wire                         inst_ready_i,
  input  wire                         redirect_valid_i,
  input  wire [fetch_pkg::xlen-1:0]   redirect_pc_i
);

  import fetch_pkg::*;

  logic [xlen-1:0] pc_q;
  logic            waiting_q;  // Set after a control-flow transfer until the redirect

  logic [6:0]      opcode;
  logic            is_ctrl;
  logic            is_fence_i;
  logic            xfer;

  assign opcode  = hit_inst_i[6:0];
  assign is_ctrl = (opcode == op_jal) || (opcode == op_jalr) ||
                   (opcode == op_branch) || (opcode == op_system);

  assign is_fence_i = (hit_inst_i == inst_fence_i);

  // The word is only offered while the cache has it and no target is pending
  assign inst_valid_o = hit_i && !waiting_q;
  assign inst_o       = hit_inst_i;
  assign pc_o         = pc_q;
  assign xfer         = inst_valid_o && inst_ready_i;

  assign fetch_pc_o  = pc_q;
  assign fetch_req_o = !waiting_q;

  // Cache clears its valid bits on the same edge that hands over FENCE.I
  assign flush_o = xfer && is_fence_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q      <= pc_reset;
      waiting_q <= 1'b0;
    end
    else if (waiting_q)
    begin
      if (redirect_valid_i)
      begin
        pc_q      <= redirect_pc_i;
        waiting_q <= 1'b0;
      end
    end
    else if (xfer)
    begin
      if (is_ctrl)
      begin
        waiting_q <= 1'b1;  // PC stays on the jump until execute resolves it
      end
      else
      begin
        pc_q <= pc_q + xlen'(4);
      end
    end
  end

endmodule

`default_nettype wire

//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // Datapath width for PCs, bus addresses and instruction words
  localparam int xlen = 32;

  // Direct-mapped cache of 4 lines with 2 words each
  localparam int line_words  = 2;
  localparam int sets        = 4;
  localparam int offset_bits = 1;   // Selects the word inside a line
  localparam int index_bits  = 2;   // Selects the line
  localparam int tag_bits    = 27;  // Bits 31..5 of the address

  // First fetch address after reset
  localparam logic [xlen-1:0] pc_reset = 32'h8000_0000;

  // Fetch stops after these control-flow opcodes until the target is known
  localparam logic [6:0] op_jal    = 7'b110_1111;
  localparam logic [6:0] op_jalr   = 7'b110_0111;
  localparam logic [6:0] op_branch = 7'b110_0011;
  localparam logic [6:0] op_system = 7'b111_0011;

  // FENCE.I with all other fields zero
  localparam logic [xlen-1:0] inst_fence_i = 32'h0000_100f;

endpackage

`default_nettype wire

//--- fetch_props.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_props (
  input wire                       clk,
  input wire                       rst,
  input wire                       mem_req_i,
  input wire [fetch_pkg::xlen-1:0] mem_addr_i,
  input wire                       mem_rvalid_i,
  input wire                       inst_valid_i,
  input wire [fetch_pkg::xlen-1:0] inst_i,
  input wire [fetch_pkg::xlen-1:0] pc_i,
  input wire                       inst_ready_i,
  input wire                       redirect_valid_i,
  input wire [fetch_pkg::xlen-1:0] redirect_pc_i
);

  import fetch_pkg::*;

  logic [xlen-1:0] next_pc_q;  // PC that the next transfer has to carry
  logic            first_req_q;
  logic            xfer;
  logic            seq_err   = 1'b0;
  logic            out_err   = 1'b0;
  logic            addr_err  = 1'b0;
  logic            rst_err   = 1'b0;
  logic            start_err = 1'b0;
  logic            any_error;

  assign xfer      = inst_valid_i && inst_ready_i;
  assign any_error = seq_err || out_err || addr_err || rst_err || start_err;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      next_pc_q   <= pc_reset;
      first_req_q <= 1'b1;
    end
    else
    begin
      if (redirect_valid_i)
        next_pc_q <= redirect_pc_i;  // Only strobed while fetch waits on a jump
      else if (xfer)
        next_pc_q <= pc_i + xlen'(4);
      if (mem_req_i)
        first_req_q <= 1'b0;
    end
  end

  pc_sequence: assert property (@(posedge clk) disable iff (rst)
    xfer |-> pc_i == next_pc_q)
  else
  begin
    seq_err = 1'b1;
    $error("Error at %0t: transfer PC is not the previous PC + 4 or the jump target", $time);
  end

  output_hold: assert property (@(posedge clk) disable iff (rst)
    inst_valid_i && !inst_ready_i |=> inst_valid_i && $stable(inst_i) && $stable(pc_i))
  else
  begin
    out_err = 1'b1;
    $error("Error at %0t: inst_o or pc_o changed while stalled", $time);
  end

  addr_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req_i && !mem_rvalid_i |=> mem_req_i && $stable(mem_addr_i))
  else
  begin
    addr_err = 1'b1;
    $error("Error at %0t: bus request dropped or moved before its response", $time);
  end

  reset_quiet: assert property (@(posedge clk)
    rst |=> !inst_valid_i && !mem_req_i)
  else
  begin
    rst_err = 1'b1;
    $error("Error at %0t: valid or bus request high right after reset", $time);
  end

  first_address: assert property (@(posedge clk) disable iff (rst)
    first_req_q && mem_req_i |-> mem_addr_i == pc_reset)
  else
  begin
    start_err = 1'b1;
    $error("Error at %0t: first bus read is not at the reset PC", $time);
  end

endmodule

`default_nettype wire

//--- fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
  input  wire                         clk,
  input  wire                         rst,
  output logic                        mem_req_o,
  output logic [fetch_pkg::xlen-1:0]  mem_addr_o,
  input  wire                         mem_rvalid_i,
  input  wire [fetch_pkg::xlen-1:0]   mem_rdata_i,
  output logic                        inst_valid_o,
  output logic [fetch_pkg::xlen-1:0]  inst_o,
  output logic [fetch_pkg::xlen-1:0]  pc_o,
  input  wire                         inst_ready_i,
  input  wire                         redirect_valid_i,
  input  wire [fetch_pkg::xlen-1:0]   redirect_pc_i
);

  import fetch_pkg::*;

  logic [xlen-1:0] fetch_pc;
  logic            fetch_req;
  logic            hit;
  logic [xlen-1:0] hit_inst;
  logic            flush;

  fetch_ctrl ctrl0 (
    .clk              (clk),
    .rst              (rst),
    .fetch_pc_o       (fetch_pc),
    .fetch_req_o      (fetch_req),
    .hit_i            (hit),
    .hit_inst_i       (hit_inst),
    .flush_o          (flush),
    .inst_valid_o     (inst_valid_o),
    .inst_o           (inst_o),
    .pc_o             (pc_o),
    .inst_ready_i     (inst_ready_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i)
  );

  icache icache0 (
    .clk          (clk),
    .rst          (rst),
    .fetch_pc_i   (fetch_pc),
    .fetch_req_i  (fetch_req),
    .flush_i      (flush),
    .hit_o        (hit),
    .hit_inst_o   (hit_inst),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

endmodule

`default_nettype wire

//--- icache.sv
`timescale 1ns/1ns
`default_nettype none

module icache (
  input  wire                         clk,
  input  wire                         rst,
  input  wire [fetch_pkg::xlen-1:0]   fetch_pc_i,
  input  wire                         fetch_req_i,
  input  wire                         flush_i,
  output logic                        hit_o,
  output logic [fetch_pkg::xlen-1:0]  hit_inst_o,
  output logic                        mem_req_o,
  output logic [fetch_pkg::xlen-1:0]  mem_addr_o,
  input  wire                         mem_rvalid_i,
  input  wire [fetch_pkg::xlen-1:0]   mem_rdata_i
);

  import fetch_pkg::*;

  typedef enum logic [1:0]
  {
    st_idle,
    st_word0,
    st_word1
  } state_t;

  state_t state_q;

  logic [xlen-1:0]        data_q [sets][line_words];
  logic [tag_bits-1:0]    tag_q [sets];
  logic [sets-1:0]        valid_q;

  // The line being refilled is captured when the miss is taken
  logic [tag_bits-1:0]    refill_tag_q;
  logic [index_bits-1:0]  refill_idx_q;

  logic [tag_bits-1:0]    pc_tag;
  logic [index_bits-1:0]  pc_idx;
  logic [offset_bits-1:0] pc_off;
  logic [offset_bits-1:0] beat;
  logic                   miss;
  logic                   beat_done;
  logic                   line_done;

  // Address layout is tag, index, word offset, then two byte bits
  assign pc_tag = fetch_pc_i[xlen-1 -: tag_bits];
  assign pc_idx = fetch_pc_i[offset_bits+2 +: index_bits];
  assign pc_off = fetch_pc_i[2 +: offset_bits];

  assign hit_o      = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign hit_inst_o = data_q[pc_idx][pc_off];

  // A refill starts only from idle, so one line is in flight at a time
  assign miss = (state_q == st_idle) && fetch_req_i && !hit_o;

  assign beat      = offset_bits'(state_q == st_word1);
  assign beat_done = (state_q != st_idle) && mem_rvalid_i;
  assign line_done = (state_q == st_word1) && mem_rvalid_i;

  // Request stays up with a fixed address until the response strobe
  assign mem_req_o  = (state_q != st_idle);
  assign mem_addr_o = {refill_tag_q, refill_idx_q, beat, 2'b00};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= st_idle;
      valid_q <= '0;
    end
    else
    begin
      if (flush_i)
      begin
        valid_q <= '0;
      end
      case (state_q)
        st_idle:
        begin
          if (miss)
          begin
            state_q         <= st_word0;
            valid_q[pc_idx] <= 1'b0;  // Old contents get overwritten word by word
          end
        end
        st_word0:
        begin
          if (mem_rvalid_i)
          begin
            state_q <= st_word1;
          end
        end
        st_word1:
        begin
          if (mem_rvalid_i)
          begin
            state_q               <= st_idle;
            valid_q[refill_idx_q] <= 1'b1;  // Written after the flush so a finishing refill stays valid
          end
        end
        default:
        begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (miss)
    begin
      refill_tag_q <= pc_tag;
      refill_idx_q <= pc_idx;
    end
    if (beat_done)
    begin
      data_q[refill_idx_q][beat] <= mem_rdata_i;
    end
    if (line_done)
    begin
      tag_q[refill_idx_q] <= refill_tag_q;
    end
  end

endmodule

`default_nettype wire

//--- sources.f
fetch_pkg.sv
icache.sv
fetch_ctrl.sv
fetch_top.sv
fetch_props.sv
tb_fetch.sv

//--- tb_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch;

  import fetch_pkg::*;

  // 23 transfers, 18 reads of up to 4 cycles each, stalls and redirects fit well inside
  localparam int max_cycles = 600;

  logic            clk;
  logic            rst;
  logic            mem_req_o;
  logic [xlen-1:0] mem_addr_o;
  logic            mem_rvalid_i;
  logic [xlen-1:0] mem_rdata_i;
  logic            inst_valid_o;
  logic [xlen-1:0] inst_o;
  logic [xlen-1:0] pc_o;
  logic            inst_ready_i;
  logic            redirect_valid_i;
  logic [xlen-1:0] redirect_pc_i;

  logic [16:0]     lfsr_q;
  logic            read_pending = 1'b0;
  int              wait_left    = 0;
  int              reads        = 0;  // Bus reads in the current loop pass
  int              jal_count    = 0;
  int              redirect_in  = 0;
  logic [xlen-1:0] redirect_target;
  logic            done       = 1'b0;
  logic            fail_shown = 1'b0;
  int              cycles     = 0;

  fetch_top dut0 (.*);

  bind fetch_top fetch_props props0 (
    .clk              (clk),
    .rst              (rst),
    .mem_req_i        (mem_req_o),
    .mem_addr_i       (mem_addr_o),
    .mem_rvalid_i     (mem_rvalid_i),
    .inst_valid_i     (inst_valid_o),
    .inst_i           (inst_o),
    .pc_i             (pc_o),
    .inst_ready_i     (inst_ready_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [16:0] lfsr_step(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};  // Taps 17 and 14
  endfunction

  task automatic take_bit(output logic b);
    b      = lfsr_q[16];
    lfsr_q = lfsr_step(lfsr_q);
  endtask

  // JAL at +0x18 closes the loop and the word after FENCE.I jumps back to the start
  function automatic logic [xlen-1:0] mem_word(input logic [xlen-1:0] addr);
    logic [xlen-1:0] word;
    logic [4:0]      rs1;
    logic [4:0]      rd;
    rs1 = addr[16:12] ^ addr[21:17];  // Upper address bits fold into the register fields
    rd  = addr[26:22] ^ addr[31:27];
    if (addr == pc_reset + 32'h18 || addr == pc_reset + 32'h20)
      word = 32'h0000_006f;  // Offset is left zero since the target comes from the redirect
    else if (addr == pc_reset + 32'h1c)
      word = 32'h0000_100f;
    else
      word = {addr[11:0], rs1, 3'b000, rd, 7'b001_0011};
    return word;
  endfunction

  task automatic fail_now(input string msg);
    fail_shown = 1'b1;
    $display("Error at %0t ns: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_reads(input int expected, input string pass_name);
    assert (reads == expected)
    else fail_now($sformatf("%s made %0d bus reads, expected %0d", pass_name, reads, expected));
  endtask

  task automatic step_cycle();
    logic b0;
    logic b1;
    mem_rvalid_i     = 1'b0;
    redirect_valid_i = 1'b0;
    if (mem_req_o)
    begin
      if (!read_pending)
      begin
        take_bit(b0);
        take_bit(b1);
        wait_left    = 1 + (b1 ? 2 : 0) + (b0 ? 1 : 0);
        read_pending = 1'b1;
        reads++;
      end
      wait_left--;
      if (wait_left == 0)
      begin
        mem_rvalid_i = 1'b1;
        mem_rdata_i  = mem_word(mem_addr_o);
        read_pending = 1'b0;
      end
    end
    if (redirect_in > 0)
    begin
      redirect_in--;
      if (redirect_in == 0)
      begin
        redirect_valid_i = 1'b1;
        redirect_pc_i    = redirect_target;
      end
    end
    take_bit(b0);
    take_bit(b1);
    inst_ready_i = !(b0 && b1);  // Consumer stalls about one cycle in four
    if (inst_valid_o && inst_ready_i)
    begin
      assert (inst_o == mem_word(pc_o))
      else fail_now($sformatf("inst_o %h at pc %h, expected %h", inst_o, pc_o, mem_word(pc_o)));
      if (inst_o[6:0] == 7'b110_1111)
      begin
        jal_count++;
        redirect_in     = 2;
        redirect_target = pc_reset;
        case (jal_count)
          1: check_reads(8, "first pass");
          2:
          begin
            check_reads(0, "second pass");
            redirect_target = pc_reset + 32'h1c;  // Single jump onto the FENCE.I
          end
          4:
          begin
            check_reads(8, "third pass after FENCE.I");
            done = 1'b1;
          end
          default: ;
        endcase
        reads = 0;
      end
    end
  endtask

  initial
  begin
    rst              = 1'b1;
    mem_rvalid_i     = 1'b0;
    mem_rdata_i      = '0;
    inst_ready_i     = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    lfsr_q           = 17'd91917;
    repeat (3) @(posedge clk);
    #10;
    rst = 1'b0;
    while (!done && cycles < max_cycles)
    begin
      step_cycle();
      @(posedge clk);
      #10;
      cycles++;
      if (dut0.props0.any_error)
        fail_now("an assertion in fetch_props failed");
    end
    if (done)
    begin
      $display("Testbench passed");
      $finish;
    end
    else
    begin
      fail_shown = 1'b1;
      $display("Timeout: the third loop pass did not end within %0d cycles", max_cycles);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  final
  begin
    if (!done && !fail_shown)
      $display("Testbench failed");
  end

endmodule

`default_nettype wire
